// ==== hw/cycle_cfg.svh ====
`ifndef CYCLE_CFG_SVH
`define CYCLE_CFG_SVH

// visible screen in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// four 4-bit colour indices per 16-bit frame buffer word
`define PIX_PER_WORD 4

// 640*480/4 = 76800 words, fits a 17-bit address
`define FB_WORDS ((`SCREEN_W * `SCREEN_H) / `PIX_PER_WORD)

// bike rectangle, long side along the heading
`define BIKE_LEN 8
`define BIKE_WID 4

// colour indices into the palette
`define COL_BG         4'h0
`define COL_RED_TRAIL  4'h4
`define COL_BLUE_TRAIL 4'hE
`define COL_RED_BIKE   4'h6
`define COL_BLUE_BIKE  4'hD
`define COL_BLOCKED    4'h7
// transparent, sprite path only
`define COL_NONE       4'hF

`endif

// ==== hw/cycle_pkg.sv ====
package cycle_pkg;

	// heading of a bike, same code as the game logic drives
	typedef enum logic [1:0]
	{
		DIR_UP    = 2'b00,
		DIR_DOWN  = 2'b01,
		DIR_LEFT  = 2'b10,
		DIR_RIGHT = 2'b11
	} dir_e;

	// one bike as seen by the pixel path
	// x, y is the head pixel
	typedef struct packed
	{
		logic [9:0] x;
		logic [9:0] y;
		dir_e       dir;
	} bike_t;

	// sprite result for one scan pixel
	typedef struct packed
	{
		// COL_NONE where no bike covers the pixel
		logic [3:0] colour;
		// pixel is directly ahead of the red head
		logic       red_probe;
		// same for the blue head
		logic       blue_probe;
	} sprite_px_t;

endpackage

// ==== hw/trail_ram.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

// trail frame buffer
// 16-bit words, four 4-bit pixels each, nibble n is x offset n
// one host write port, one scan read port
module trail_ram
(
	input  logic        Clk,
	input  logic        we,
	input  logic [16:0] write_address,
	input  logic [15:0] data_in,
	input  logic [16:0] read_address,
	output logic [15:0] data_out
);

	// trail history, written by the host only
	logic [15:0] mem [0:`FB_WORDS-1];

	// write port
	// new word is seen by reads from the next edge on
	always_ff @(posedge Clk)
	begin
		if (we)
		begin
			mem[write_address] <= data_in;
		end
	end

	// registered read, one cycle latency
	// same-edge write returns the old word
	always_ff @(posedge Clk)
	begin
		data_out <= mem[read_address];
	end

endmodule

// ==== hw/bike_render.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

// sprite colour and head probes for the current scan pixel
// bikes are solid rectangles, head at one short end
module bike_render import cycle_pkg::*;
(
	input  logic       Clk,
	input  logic       rst_n,
	input  logic [9:0] draw_x,
	input  logic [9:0] draw_y,
	input  bike_t      red_bike,
	input  bike_t      blue_bike,
	output sprite_px_t sprite
);

	// across the heading: one pixel before the head, two after
	localparam int LAT_LO = `BIKE_WID / 2 - 1;
	localparam int LAT_HI = `BIKE_WID / 2;
	// along the heading: head plus tail pixels behind it
	localparam int TAIL = `BIKE_LEN - 1;

	logic       red_hit;
	logic       blue_hit;
	logic       red_ahead;
	logic       blue_ahead;
	sprite_px_t sprite_next;

	// true when (px, py) lies inside the rectangle of bike b
	function automatic logic in_rect(input bike_t b, input logic [9:0] px,
		input logic [9:0] py);
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		logic               lat_x;
		logic               lat_y;
		// signed offsets from the head, no wrap at the screen edge
		dx = $signed({2'b00, px}) - $signed({2'b00, b.x});
		dy = $signed({2'b00, py}) - $signed({2'b00, b.y});
		lat_x = (dx >= -LAT_LO) && (dx <= LAT_HI);
		lat_y = (dy >= -LAT_LO) && (dy <= LAT_HI);
		case (b.dir)
			// moving up, tail hangs below the head
			DIR_UP:    in_rect = lat_x && (dy >= 0) && (dy <= TAIL);
			DIR_DOWN:  in_rect = lat_x && (dy >= -TAIL) && (dy <= 0);
			// moving left, tail to the right
			DIR_LEFT:  in_rect = lat_y && (dx >= 0) && (dx <= TAIL);
			default:   in_rect = lat_y && (dx >= -TAIL) && (dx <= 0);
		endcase
	endfunction

	// true when (px, py) is the head moved one step forward
	function automatic logic is_probe(input bike_t b, input logic [9:0] px,
		input logic [9:0] py);
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		dx = $signed({2'b00, px}) - $signed({2'b00, b.x});
		dy = $signed({2'b00, py}) - $signed({2'b00, b.y});
		case (b.dir)
			DIR_UP:    is_probe = (dx == 0) && (dy == -1);
			DIR_DOWN:  is_probe = (dx == 0) && (dy == 1);
			DIR_LEFT:  is_probe = (dx == -1) && (dy == 0);
			default:   is_probe = (dx == 1) && (dy == 0);
		endcase
	endfunction

	always_comb
	begin
		red_hit    = in_rect(red_bike, draw_x, draw_y);
		blue_hit   = in_rect(blue_bike, draw_x, draw_y);
		red_ahead  = is_probe(red_bike, draw_x, draw_y);
		blue_ahead = is_probe(blue_bike, draw_x, draw_y);

		// red drawn on top where the bikes overlap
		if (red_hit)
			sprite_next.colour = `COL_RED_BIKE;
		else if (blue_hit)
			sprite_next.colour = `COL_BLUE_BIKE;
		else
			sprite_next.colour = `COL_NONE;

		sprite_next.red_probe  = red_ahead;
		sprite_next.blue_probe = blue_ahead;
	end

	// one cycle behind draw_x/draw_y, lines up with the ram read
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			sprite.colour     <= `COL_NONE;
			sprite.red_probe  <= 1'b0;
			sprite.blue_probe <= 1'b0;
		end
		else
		begin
			sprite <= sprite_next;
		end
	end

endmodule

// ==== hw/pixel_combine.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

// merges the trail word and the sprite into one colour index
// also flags a crash when a head probe lands on trail
module pixel_combine import cycle_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  logic [9:0]  draw_x,
	input  logic        is_blocked,
	input  logic [15:0] trail_word,
	input  sprite_px_t  sprite,
	output logic [3:0]  color_enum,
	output logic        red_crash,
	output logic        blue_crash
);

	// scan-side inputs, delayed to meet the ram and sprite data
	logic [1:0] sel_q;
	logic       blocked_q;

	// merge results before the output register
	logic [3:0] trail_px;
	logic [3:0] color_next;
	logic       red_crash_next;
	logic       blue_crash_next;

	// low x bits pick the nibble, payload only
	always_ff @(posedge Clk)
	begin
		sel_q <= draw_x[1:0];
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			blocked_q <= 1'b0;
		end
		else
		begin
			blocked_q <= is_blocked;
		end
	end

	// nibble n sits in bits 4n+3..4n
	assign trail_px = trail_word[{sel_q, 2'b00} +: 4];

	always_comb
	begin
		// blocked wins over everything
		if (blocked_q)
		begin
			color_next = `COL_BLOCKED;
		end
		// then any bike sprite
		else if (sprite.colour != `COL_NONE)
		begin
			color_next = sprite.colour;
		end
		// else whatever trail is stored
		else
		begin
			color_next = trail_px;
		end
	end

	always_comb
	begin
		// probe pixel already holds trail of either colour
		red_crash_next  = sprite.red_probe && (trail_px != `COL_BG);
		blue_crash_next = sprite.blue_probe && (trail_px != `COL_BG);
	end

	// output stage, two cycles after draw_x at the top
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			color_enum <= `COL_BG;
			red_crash  <= 1'b0;
			blue_crash <= 1'b0;
		end
		else
		begin
			color_enum <= color_next;
			red_crash  <= red_crash_next;
			blue_crash <= blue_crash_next;
		end
	end

endmodule

// ==== hw/cycle_display.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

// light-cycle pixel path
// trail lookup and bike sprites run side by side, then get merged
module cycle_display import cycle_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  logic [9:0]  DrawX,
	input  logic [9:0]  DrawY,
	input  logic        is_blocked,
	input  logic        WE,
	input  logic [16:0] write_address,
	input  logic [15:0] Data_In,
	input  bike_t       red_bike,
	input  bike_t       blue_bike,
	output logic [3:0]  color_enum,
	output logic        red_crash,
	output logic        blue_crash,
	output logic [15:0] dOut
);

	// linear pixel index, up to 307199
	logic [18:0] pix_index;
	logic [16:0] read_address;
	logic [15:0] trail_word;
	sprite_px_t  sprite;

	// word holding this pixel
	assign pix_index    = 19'(DrawY) * 19'(`SCREEN_W) + 19'(DrawX);
	assign read_address = 17'(pix_index / `PIX_PER_WORD);

	// host writes go straight to the buffer
	trail_ram u_trail_ram
	(
		.Clk           (Clk),
		.we            (WE),
		.write_address (write_address),
		.data_in       (Data_In),
		.read_address  (read_address),
		.data_out      (trail_word)
	);

	bike_render u_bike_render
	(
		.Clk       (Clk),
		.rst_n     (rst_n),
		.draw_x    (DrawX),
		.draw_y    (DrawY),
		.red_bike  (red_bike),
		.blue_bike (blue_bike),
		.sprite    (sprite)
	);

	pixel_combine u_pixel_combine
	(
		.Clk        (Clk),
		.rst_n      (rst_n),
		.draw_x     (DrawX),
		.is_blocked (is_blocked),
		.trail_word (trail_word),
		.sprite     (sprite),
		.color_enum (color_enum),
		.red_crash  (red_crash),
		.blue_crash (blue_crash)
	);

	// raw trail word, one cycle behind DrawX/DrawY
	assign dOut = trail_word;

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

// testbench clock, 40 ns period
// reset held low for the first three rising edges
module clock_gen
(
	output logic Clk,
	output logic rst_n
);

	initial
	begin
		Clk   = 1'b0;
		rst_n = 1'b0;
		// release on an edge, like any other synchronous input
		repeat (3) @(posedge Clk);
		rst_n <= 1'b1;
	end

	always #20 Clk = ~Clk;

endmodule

// ==== bench/cycle_assertions.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

// protocol checks on the pixel path outputs
module cycle_assertions
(
	input logic       Clk,
	input logic       rst_n,
	input logic       is_blocked,
	input logic [3:0] color_enum,
	input logic       red_crash,
	input logic       blue_crash
);

	// first cycle out of reset, crash flags still cleared
	crash_clear_after_reset: assert property (@(posedge Clk)
		(rst_n && !$past(rst_n)) |-> (!red_crash && !blue_crash))
		else $error("crash flag set in the first cycle after reset");

	// blocked pixel shows up two cycles later
	blocked_colour: assert property (@(posedge Clk) disable iff (!rst_n)
		is_blocked |-> ##2 (color_enum == `COL_BLOCKED))
		else $error("blocked pixel not drawn in the blocked colour");

	// probe pixel holds trail, so never background
	crash_not_bg: assert property (@(posedge Clk) disable iff (!rst_n)
		(red_crash || blue_crash) |-> (color_enum != `COL_BG))
		else $error("crash flagged on a background pixel");

endmodule

bind cycle_display cycle_assertions u_cycle_assertions
(
	.Clk        (Clk),
	.rst_n      (rst_n),
	.is_blocked (is_blocked),
	.color_enum (color_enum),
	.red_crash  (red_crash),
	.blue_crash (blue_crash)
);

// ==== bench/tb_cycle_display.sv ====
`timescale 1ns/10ps

`include "cycle_cfg.svh"

module tb_cycle_display import cycle_pkg::*;
();

	// one scan pixel with its expected result
	typedef struct packed
	{
		logic [9:0]  x;
		logic [9:0]  y;
		logic        blk;
		bike_t       red;
		bike_t       blue;
		logic        wr;
		logic [15:0] wdata;
		logic [15:0] word;
		logic [3:0]  col;
		logic        rc;
		logic        bc;
	} row_t;

	// preloaded window, 32 x 16 pixels at (96, 96)
	localparam int WIN_X = 96;
	localparam int WIN_Y = 96;
	localparam int WIN_ROWS = 16;
	localparam int WIN_COLS = 8;
	localparam int PRELOAD_N = WIN_ROWS * WIN_COLS;
	localparam int RAND_N = 40;

	logic        Clk;
	logic        rst_n;
	logic [9:0]  DrawX;
	logic [9:0]  DrawY;
	logic        is_blocked;
	logic        WE;
	logic [16:0] write_address;
	logic [15:0] Data_In;
	bike_t       red_bike;
	bike_t       blue_bike;
	logic [3:0]  color_enum;
	logic        red_crash;
	logic        blue_crash;
	logic [15:0] dOut;

	// trail patterns, picked per word by (col + row) mod 8
	logic [15:0] pat [0:7];
	logic [15:0] model_mem [0:WIN_ROWS-1][0:WIN_COLS-1];

	row_t   rows[$];
	row_t   pending[$];
	integer seed = 73382;
	int     mismatch_count = 0;
	int     other_errors = 0;
	int     check_count = 0;
	bit     rows_ready = 0;

	clock_gen u_clock_gen
	(
		.Clk   (Clk),
		.rst_n (rst_n)
	);

	cycle_display DUT
	(
		.Clk           (Clk),
		.rst_n         (rst_n),
		.DrawX         (DrawX),
		.DrawY         (DrawY),
		.is_blocked    (is_blocked),
		.WE            (WE),
		.write_address (write_address),
		.Data_In       (Data_In),
		.red_bike      (red_bike),
		.blue_bike     (blue_bike),
		.color_enum    (color_enum),
		.red_crash     (red_crash),
		.blue_crash    (blue_crash),
		.dOut          (dOut)
	);

	function automatic bike_t mk_bike(input int x, input int y, input dir_e d);
		bike_t b;
		b.x = 10'(x);
		b.y = 10'(y);
		b.dir = d;
		return b;
	endfunction

	// word index of a screen pixel
	function automatic logic [16:0] word_addr(input int x, input int y);
		return 17'((y * `SCREEN_W + x) / `PIX_PER_WORD);
	endfunction

	// reference word held at a window pixel
	function automatic logic [15:0] stored_word(input int x, input int y);
		return model_mem[y - WIN_Y][(x - WIN_X) / 4];
	endfunction

	// reference trail lookup inside the window
	function automatic logic [3:0] trail_model(input int x, input int y);
		logic [15:0] w;
		w = stored_word(x, y);
		return w[(x % 4) * 4 +: 4];
	endfunction

	// bike rectangle, head at the front short end
	function automatic bit covers(input bike_t b, input int px, input int py);
		int dx;
		int dy;
		dx = px - int'(b.x);
		dy = py - int'(b.y);
		case (b.dir)
			DIR_UP:   return dx >= -1 && dx <= 2 && dy >= 0 && dy <= 7;
			DIR_DOWN: return dx >= -1 && dx <= 2 && dy >= -7 && dy <= 0;
			DIR_LEFT: return dy >= -1 && dy <= 2 && dx >= 0 && dx <= 7;
			default:  return dy >= -1 && dy <= 2 && dx >= -7 && dx <= 0;
		endcase
	endfunction

	// one step ahead of the head
	function automatic bit ahead(input bike_t b, input int px, input int py);
		int hx;
		int hy;
		hx = int'(b.x);
		hy = int'(b.y);
		case (b.dir)
			DIR_UP:   hy = hy - 1;
			DIR_DOWN: hy = hy + 1;
			DIR_LEFT: hx = hx - 1;
			default:  hx = hx + 1;
		endcase
		return px == hx && py == hy;
	endfunction

	task automatic predict(inout row_t r);
		logic [3:0] t;
		t = trail_model(int'(r.x), int'(r.y));
		r.word = stored_word(int'(r.x), int'(r.y));
		if (r.blk)
			r.col = `COL_BLOCKED;
		else if (covers(r.red, int'(r.x), int'(r.y)))
			r.col = `COL_RED_BIKE;
		else if (covers(r.blue, int'(r.x), int'(r.y)))
			r.col = `COL_BLUE_BIKE;
		else
			r.col = t;
		r.rc = ahead(r.red, int'(r.x), int'(r.y)) && t != `COL_BG;
		r.bc = ahead(r.blue, int'(r.x), int'(r.y)) && t != `COL_BG;
	endtask

	task automatic add_row(input int x, input int y, input bit blk, input bike_t r,
		input bike_t b, input bit wr, input logic [15:0] wdata, input logic [3:0] col,
		input bit rc, input bit bc);
		row_t e;
		e.x = 10'(x);
		e.y = 10'(y);
		e.blk = blk;
		e.red = r;
		e.blue = b;
		e.wr = wr;
		e.wdata = wdata;
		e.col = col;
		e.rc = rc;
		e.bc = bc;
		// same-edge read still returns the old word
		e.word = stored_word(x, y);
		rows.push_back(e);
		// rewrite lands after this row's own read
		if (wr)
			model_mem[y - WIN_Y][(x - WIN_X) / 4] = wdata;
	endtask

	task automatic build_rows();
		bike_t pr;
		bike_t pb;
		row_t  e;
		pr = mk_bike(600, 400, DIR_UP);
		pb = mk_bike(560, 400, DIR_UP);
		// readback, nibbles 0..3
		add_row(104, 97, 0, pr, pb, 0, 0, 4'hE, 0, 0);
		add_row(105, 97, 0, pr, pb, 0, 0, 4'h4, 0, 0);
		add_row(102, 97, 0, pr, pb, 0, 0, 4'h4, 0, 0);
		add_row(103, 97, 0, pr, pb, 0, 0, 4'hE, 0, 0);
		// red heading up, probe on trail
		add_row(109, 100, 0, mk_bike(110, 100, DIR_UP), pb, 0, 0, 4'h6, 0, 0);
		add_row(112, 107, 0, mk_bike(110, 100, DIR_UP), pb, 0, 0, 4'h6, 0, 0);
		add_row(108, 100, 0, mk_bike(110, 100, DIR_UP), pb, 0, 0, 4'hE, 0, 0);
		add_row(110, 108, 0, mk_bike(110, 100, DIR_UP), pb, 0, 0, 4'h4, 0, 0);
		add_row(110, 99, 0, mk_bike(110, 100, DIR_UP), pb, 0, 0, 4'hE, 1, 0);
		// blue heading down, probe on background
		add_row(99, 103, 0, pr, mk_bike(100, 110, DIR_DOWN), 0, 0, 4'hD, 0, 0);
		add_row(102, 110, 0, pr, mk_bike(100, 110, DIR_DOWN), 0, 0, 4'hD, 0, 0);
		add_row(103, 105, 0, pr, mk_bike(100, 110, DIR_DOWN), 0, 0, 4'hE, 0, 0);
		add_row(100, 111, 0, pr, mk_bike(100, 110, DIR_DOWN), 0, 0, 4'h0, 0, 0);
		// red heading left
		add_row(119, 106, 0, mk_bike(112, 104, DIR_LEFT), pb, 0, 0, 4'h6, 0, 0);
		add_row(112, 103, 0, mk_bike(112, 104, DIR_LEFT), pb, 0, 0, 4'h6, 0, 0);
		add_row(120, 104, 0, mk_bike(112, 104, DIR_LEFT), pb, 0, 0, 4'hE, 0, 0);
		add_row(111, 104, 0, mk_bike(112, 104, DIR_LEFT), pb, 0, 0, 4'h0, 0, 0);
		// blue heading right
		add_row(109, 99, 0, pr, mk_bike(116, 100, DIR_RIGHT), 0, 0, 4'hD, 0, 0);
		add_row(116, 102, 0, pr, mk_bike(116, 100, DIR_RIGHT), 0, 0, 4'hD, 0, 0);
		add_row(108, 101, 0, pr, mk_bike(116, 100, DIR_RIGHT), 0, 0, 4'h0, 0, 0);
		add_row(117, 100, 0, pr, mk_bike(116, 100, DIR_RIGHT), 0, 0, 4'h0, 0, 0);
		// probes on trail, remaining directions
		add_row(106, 97, 0, mk_bike(106, 96, DIR_DOWN), pb, 0, 0, 4'hE, 1, 0);
		add_row(97, 108, 0, mk_bike(96, 108, DIR_RIGHT), pb, 0, 0, 4'h4, 1, 0);
		add_row(104, 98, 0, pr, mk_bike(105, 98, DIR_LEFT), 0, 0, 4'h4, 0, 1);
		add_row(113, 104, 0, pr, mk_bike(113, 105, DIR_UP), 0, 0, 4'h4, 0, 1);
		add_row(123, 110, 0, pr, mk_bike(122, 110, DIR_RIGHT), 0, 0, 4'h4, 0, 1);
		// priority: red over blue, blue over trail, blocked over all
		add_row(110, 100, 0, mk_bike(110, 100, DIR_UP), mk_bike(116, 100, DIR_RIGHT),
			0, 0, 4'h6, 0, 0);
		add_row(109, 99, 0, mk_bike(110, 100, DIR_UP), mk_bike(116, 100, DIR_RIGHT),
			0, 0, 4'hD, 0, 0);
		add_row(110, 100, 1, mk_bike(110, 100, DIR_UP), mk_bike(116, 100, DIR_RIGHT),
			0, 0, 4'h7, 0, 0);
		add_row(110, 99, 1, mk_bike(110, 100, DIR_UP), mk_bike(116, 100, DIR_RIGHT),
			0, 0, 4'h7, 1, 0);
		// rewrite mid-scan, same-cycle read still old
		add_row(100, 97, 0, pr, pb, 1, 16'h5A3C, 4'h0, 0, 0);
		add_row(101, 97, 0, pr, pb, 0, 0, 4'h3, 0, 0);
		add_row(103, 97, 0, pr, pb, 0, 0, 4'h5, 0, 0);
		// random background rows, model gives the expected side
		for (int i = 0; i < RAND_N; i++)
		begin
			e = '0;
			e.x = 10'(WIN_X + ($random(seed) & 31));
			e.y = 10'(WIN_Y + ($random(seed) & 15));
			e.blk = (($random(seed) & 7) == 0);
			e.red = mk_bike(WIN_X + ($random(seed) & 31), WIN_Y + ($random(seed) & 15),
				dir_e'(2'($random(seed))));
			e.blue = mk_bike(WIN_X + ($random(seed) & 31), WIN_Y + ($random(seed) & 15),
				dir_e'(2'($random(seed))));
			predict(e);
			rows.push_back(e);
		end
	endtask

	task automatic check_row(input row_t e);
		check_count++;
		if (color_enum !== e.col)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: color_enum expected %h got %h (x %0d y %0d)",
				$time, e.col, color_enum, e.x, e.y);
		end
		if (red_crash !== e.rc)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: red_crash expected %b got %b (x %0d y %0d)",
				$time, e.rc, red_crash, e.x, e.y);
		end
		if (blue_crash !== e.bc)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: blue_crash expected %b got %b (x %0d y %0d)",
				$time, e.bc, blue_crash, e.x, e.y);
		end
	endtask

	// raw trail word, one cycle after its address
	task automatic compare_dout(input row_t e);
		check_count++;
		if (dOut !== e.word)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: dOut expected %h got %h (x %0d y %0d)",
				$time, e.word, dOut, e.x, e.y);
		end
	endtask

	// watchdog, sized from the preload and the table
	initial
	begin
		wait (rows_ready);
		#((PRELOAD_N + rows.size() + 20) * 40);
		other_errors++;
		$display("timeout: scan did not finish in time");
		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		row_t e;
		DrawX = 0;
		DrawY = 0;
		is_blocked = 0;
		WE = 0;
		write_address = 0;
		Data_In = 0;
		red_bike = mk_bike(600, 400, DIR_UP);
		blue_bike = mk_bike(560, 400, DIR_UP);
		pat[0] = 16'h0000;
		pat[1] = 16'h4E04;
		pat[2] = 16'hE400;
		pat[3] = 16'h0E4E;
		pat[4] = 16'h4444;
		pat[5] = 16'h00E0;
		pat[6] = 16'hEEEE;
		pat[7] = 16'h040E;
		for (int r = 0; r < WIN_ROWS; r++)
			for (int c = 0; c < WIN_COLS; c++)
				model_mem[r][c] = pat[(c + r) % 8];
		build_rows();
		rows_ready = 1;

		// outputs right after reset
		wait (rst_n === 1'b1);
		@(negedge Clk);
		e = '0;
		e.col = `COL_BG;
		check_row(e);

		// preload the window from the pattern table
		for (int r = 0; r < WIN_ROWS; r++)
		begin
			for (int c = 0; c < WIN_COLS; c++)
			begin
				@(posedge Clk);
				WE <= 1'b1;
				write_address <= word_addr(WIN_X + 4 * c, WIN_Y + r);
				Data_In <= pat[(c + r) % 8];
			end
		end

		// scan the table back to back, results two cycles later
		for (int i = 0; i < rows.size() + 2; i++)
		begin
			@(posedge Clk);
			if (i < rows.size())
			begin
				e = rows[i];
				DrawX <= e.x;
				DrawY <= e.y;
				is_blocked <= e.blk;
				red_bike <= e.red;
				blue_bike <= e.blue;
				WE <= e.wr;
				write_address <= word_addr(int'(e.x), int'(e.y));
				Data_In <= e.wdata;
				pending.push_back(e);
			end
			else
			begin
				WE <= 1'b0;
				is_blocked <= 1'b0;
			end
			@(negedge Clk);
			// dOut trails the scan by one row
			if (i >= 1 && i <= rows.size())
				compare_dout(rows[i - 1]);
			if (i >= 2)
				check_row(pending.pop_front());
		end

		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hw
hw/cycle_pkg.sv
hw/trail_ram.sv
hw/bike_render.sv
hw/pixel_combine.sv
hw/cycle_display.sv
bench/clock_gen.sv
bench/cycle_assertions.sv
bench/tb_cycle_display.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_cycle_display \
	-o tb_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
